// ==== flist.f ====
source/dot_pkg.sv
source/dot_mult_stage.sv
source/dot_add_level.sv
source/dot_product_pipe.sv
test/dot_product_assert.sv
test/dot_product_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    --top-module dot_product_tb \
    -f flist.f

# A failing run still leaves its log for the search below
./obj_dir/Vdot_product_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "^TB PASSED$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// ==== source/dot_add_level.sv ====
`timescale 1ns/100ps
`default_nettype none

module dot_add_level #(
    parameter int IN_COUNT = 8,
    parameter int IN_W     = 16
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [IN_W-1:0] operands [IN_COUNT],
    input  logic            in_valid,
    input  logic            in_last,
    output logic [IN_W:0]   sums     [IN_COUNT/2],
    output logic            out_valid,
    output logic            out_last
);

    // ############################################################
    // Pairwise adders
    // ############################################################

    // Operands 2i and 2i+1 feed sum i
    // One extra bit per sum keeps the carry
    always_ff @(posedge clk or negedge rst_n) begin : proc_sums
        if (!rst_n) begin
            for (int i = 0; i < IN_COUNT / 2; i++) begin
                sums[i] <= '0;
            end
        end else if (in_valid) begin
            for (int i = 0; i < IN_COUNT / 2; i++) begin
                sums[i] <= operands[2*i] + operands[2*i+1];
            end
        end
    end

    // ############################################################
    // Flag stage
    // ############################################################

    // Valid moves one edge forward with the data
    always_ff @(posedge clk or negedge rst_n) begin : proc_valid
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Cleared on idle cycles so last never shows without valid
    always_ff @(posedge clk or negedge rst_n) begin : proc_last
        if (!rst_n) begin
            out_last <= 1'b0;
        end else if (in_valid) begin
            out_last <= in_last;
        end else begin
            out_last <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/dot_mult_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module dot_mult_stage (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           compute,
    input  logic           in_last,
    input  dot_pkg::vec_t  vec_a,
    input  dot_pkg::vec_t  vec_b,
    output dot_pkg::prod_t products [dot_pkg::VEC_LEN],
    output logic           prod_valid,
    output logic           prod_last
);

    // ############################################################
    // Element-wise multiply
    // ############################################################

    // Products registered at the sampling edge
    // Held while compute is low so the bus stays stable
    always_ff @(posedge clk or negedge rst_n) begin : proc_products
        if (!rst_n) begin
            for (int i = 0; i < dot_pkg::VEC_LEN; i++) begin
                products[i] <= '0;
            end
        end else if (compute) begin
            for (int i = 0; i < dot_pkg::VEC_LEN; i++) begin
                // Widen before the multiply to keep the full product
                products[i] <= dot_pkg::prod_t'(vec_a[i]) * dot_pkg::prod_t'(vec_b[i]);
            end
        end
    end

    // ############################################################
    // Item flags
    // ############################################################

    // Valid is a single-cycle pulse per accepted item
    always_ff @(posedge clk or negedge rst_n) begin : proc_valid
        if (!rst_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= compute;
        end
    end

    // Last only travels together with a valid item
    always_ff @(posedge clk or negedge rst_n) begin : proc_last
        if (!rst_n) begin
            prod_last <= 1'b0;
        end else if (compute) begin
            prod_last <= in_last;
        end else begin
            prod_last <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/dot_pkg.sv ====
`default_nettype none

package dot_pkg;

    // ############################################################
    // Vector geometry
    // ############################################################

    // Elements per vector
    localparam int VEC_LEN = 8;

    // Width of one unsigned element
    localparam int ELEM_W = 8;

    // Full product of two elements
    localparam int PROD_W = 2 * ELEM_W;

    // Each tree level adds one carry bit
    localparam int SUM_W = PROD_W + $clog2(VEC_LEN);

    // ############################################################
    // Pipeline timing
    // ############################################################

    // Edges from the sampling edge to the edge that presents the sum
    localparam int PIPE_LAT = 3;

    // ############################################################
    // Data types
    // ############################################################

    typedef logic [ELEM_W-1:0] elem_t;

    // Element 0 in the low bits
    typedef elem_t [VEC_LEN-1:0] vec_t;

    typedef logic [PROD_W-1:0] prod_t;

    typedef logic [SUM_W-1:0] result_t;

endpackage

`default_nettype wire

// ==== source/dot_product_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

module dot_product_pipe (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             compute,
    input  logic             in_last,
    input  dot_pkg::vec_t    vec_a,
    input  dot_pkg::vec_t    vec_b,
    output dot_pkg::result_t dot_product,
    output logic             out_valid,
    output logic             out_last
);

    // ############################################################
    // Inter-stage buses
    // ############################################################

    // Multiply stage to level 1
    dot_pkg::prod_t               products [dot_pkg::VEC_LEN];
    logic                         prod_valid;
    logic                         prod_last;

    // Level 1 to level 2
    logic [dot_pkg::PROD_W:0]     sum_l1   [dot_pkg::VEC_LEN/2];
    logic                         valid_l1;
    logic                         last_l1;

    // Level 2 to level 3
    logic [dot_pkg::PROD_W+1:0]   sum_l2   [dot_pkg::VEC_LEN/4];
    logic                         valid_l2;
    logic                         last_l2;

    // Single remaining sum
    logic [dot_pkg::SUM_W-1:0]    sum_l3   [1];

    // ############################################################
    // Multiply stage registers at the sampling edge
    // ############################################################

    dot_mult_stage dot_mult_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .compute    (compute),
        .in_last    (in_last),
        .vec_a      (vec_a),
        .vec_b      (vec_b),
        .products   (products),
        .prod_valid (prod_valid),
        .prod_last  (prod_last)
    );

    // ############################################################
    // Adder tree with one register per level
    // ############################################################

    // 8 products of 16 bits down to 4 sums
    dot_add_level #(
        .IN_COUNT (dot_pkg::VEC_LEN),
        .IN_W     (dot_pkg::PROD_W)
    ) level1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .operands  (products),
        .in_valid  (prod_valid),
        .in_last   (prod_last),
        .sums      (sum_l1),
        .out_valid (valid_l1),
        .out_last  (last_l1)
    );

    dot_add_level #(
        .IN_COUNT (dot_pkg::VEC_LEN / 2),
        .IN_W     (dot_pkg::PROD_W + 1)
    ) level2 (
        .clk       (clk),
        .rst_n     (rst_n),
        .operands  (sum_l1),
        .in_valid  (valid_l1),
        .in_last   (last_l1),
        .sums      (sum_l2),
        .out_valid (valid_l2),
        .out_last  (last_l2)
    );

    // Final level drives the top-level flags directly
    dot_add_level #(
        .IN_COUNT (dot_pkg::VEC_LEN / 4),
        .IN_W     (dot_pkg::PROD_W + 2)
    ) level3 (
        .clk       (clk),
        .rst_n     (rst_n),
        .operands  (sum_l2),
        .in_valid  (valid_l2),
        .in_last   (last_l2),
        .sums      (sum_l3),
        .out_valid (out_valid),
        .out_last  (out_last)
    );

    assign dot_product = sum_l3[0];

endmodule

`default_nettype wire

// ==== test/dot_product_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module dot_product_assert (
    input logic clk,
    input logic rst_n,
    input logic compute,
    input logic out_valid,
    input logic out_last
);

    // ############################################################
    // Pipeline protocol
    // ############################################################

    // The presenting edge is seen by the sampled values one edge later
    valid_from_item: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(compute, dot_pkg::PIPE_LAT + 1))
        else $error("out_valid without an accepted item at the expected edge");

    item_to_valid: assert property (@(posedge clk) disable iff (!rst_n)
        $past(compute, dot_pkg::PIPE_LAT + 1) |-> out_valid)
        else $error("accepted item did not produce out_valid after the fixed latency");

    // Last never shows on an idle cycle
    last_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
        out_last |-> out_valid)
        else $error("out_last high while out_valid is low");

endmodule

bind dot_product_pipe dot_product_assert dot_product_assert_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .compute   (compute),
    .out_valid (out_valid),
    .out_last  (out_last)
);

`default_nettype wire

// ==== test/dot_product_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module dot_product_tb;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             compute;
    logic             in_last;
    dot_pkg::vec_t    vec_a;
    dot_pkg::vec_t    vec_b;
    dot_pkg::result_t dot_product;
    logic             out_valid;
    logic             out_last;

    // Expected results in issue order
    dot_pkg::result_t exp_q[$];
    logic             last_q[$];
    int               sent_count = 0;
    int               recv_count = 0;
    string            test_name  = "reset";

    always #2 clk = ~clk;

    dot_product_pipe dot_product_pipe_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .compute     (compute),
        .in_last     (in_last),
        .vec_a       (vec_a),
        .vec_b       (vec_b),
        .dot_product (dot_product),
        .out_valid   (out_valid),
        .out_last    (out_last)
    );

    // ############################################################
    // Reference model and error reporting
    // ############################################################

    // Serial sum of element products
    function automatic dot_pkg::result_t dot_ref(input dot_pkg::vec_t a, input dot_pkg::vec_t b);
        dot_pkg::result_t acc;
        acc = '0;
        for (int i = 0; i < dot_pkg::VEC_LEN; i++) begin
            acc += dot_pkg::result_t'(a[i]) * dot_pkg::result_t'(b[i]);
        end
        return acc;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("[FAIL] %s expected %0d actual %0d", name, exp_val, act_val);
        $display("TB FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_error(input string msg);
        $display("[ERROR] %s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // ############################################################
    // Stimulus helpers
    // ############################################################

    task automatic send_item(input dot_pkg::vec_t a, input dot_pkg::vec_t b,
                             input logic last, input dot_pkg::result_t exp_sum);
        @(posedge clk);
        #1;
        compute = 1'b1;
        vec_a   = a;
        vec_b   = b;
        in_last = last;
        exp_q.push_back(exp_sum);
        last_q.push_back(last);
        sent_count++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        compute = 1'b0;
        in_last = 1'b0;
    endtask

    task automatic send_random(input logic last);
        dot_pkg::vec_t a;
        dot_pkg::vec_t b;
        a = {$urandom, $urandom};
        b = {$urandom, $urandom};
        send_item(a, b, last, dot_ref(a, b));
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 50) begin
            @(posedge clk);
            cycles++;
        end
        assert (exp_q.size() == 0)
            else report_error($sformatf("%s: results still missing after timeout", test_name));
    endtask

    task automatic check_idle_outputs();
        assert (out_valid == 1'b0) else report_mismatch({test_name, " valid"}, 0, 32'(out_valid));
        assert (out_last == 1'b0) else report_mismatch({test_name, " last"}, 0, 32'(out_last));
        assert (dot_product == '0) else report_mismatch(test_name, 0, 32'(dot_product));
    endtask

    task automatic check_latency();
        int edges;
        send_random(1'b1);
        // Sampling edge of the item
        @(posedge clk);
        #1;
        compute = 1'b0;
        in_last = 1'b0;
        edges = 0;
        while (!out_valid && edges < 20) begin
            @(posedge clk);
            edges++;
            #1;
        end
        assert (edges == dot_pkg::PIPE_LAT)
            else report_mismatch("latency", dot_pkg::PIPE_LAT, edges);
    endtask

    // ############################################################
    // Scoreboard
    // ############################################################

    always @(negedge clk) begin : compare_results
        dot_pkg::result_t exp_sum;
        logic             exp_last;
        if (rst_n && out_valid) begin
            assert (exp_q.size() != 0)
                else report_error("a result appeared with no item outstanding");
            exp_sum  = exp_q.pop_front();
            exp_last = last_q.pop_front();
            recv_count++;
            assert (dot_product == exp_sum)
                else report_mismatch(test_name, 32'(exp_sum), 32'(dot_product));
            assert (out_last == exp_last)
                else report_mismatch({test_name, " last"}, 32'(exp_last), 32'(out_last));
        end
    end

    // ############################################################
    // Test sequence
    // ############################################################

    initial begin : main_sequence
        dot_pkg::vec_t a;
        dot_pkg::vec_t b;
        void'($urandom(18100));
        rst_n   = 1'b0;
        compute = 1'b0;
        in_last = 1'b0;
        vec_a   = '0;
        vec_b   = '0;

        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            check_idle_outputs();
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int c = 0; c < 10; c++) begin
            @(negedge clk);
            check_idle_outputs();
        end

        // Both items are in flight together
        test_name = "ones_and_max";
        send_item({dot_pkg::VEC_LEN{8'h01}}, {dot_pkg::VEC_LEN{8'h01}}, 1'b0, 8);
        send_item('1, '1, 1'b1, 520200);
        idle_cycle();
        wait_drain();

        // Distinct product per index exposes the pairing order
        test_name = "single_index";
        for (int i = 0; i < dot_pkg::VEC_LEN; i++) begin
            a = '0;
            b = '0;
            a[i] = dot_pkg::elem_t'(i + 3);
            b[i] = dot_pkg::elem_t'(2 * i + 5);
            send_item(a, b, 1'b0, dot_pkg::result_t'((i + 3) * (2 * i + 5)));
        end
        idle_cycle();
        wait_drain();

        test_name = "latency";
        check_latency();
        wait_drain();

        test_name = "stream";
        for (int i = 0; i < 200; i++) begin
            send_random(1'b0);
        end
        idle_cycle();
        wait_drain();

        test_name = "gaps";
        for (int i = 0; i < 300; ) begin
            if ($urandom % 2 == 0) begin
                send_random($urandom % 4 == 0);
                i++;
            end else begin
                idle_cycle();
            end
        end
        idle_cycle();
        wait_drain();

        if (recv_count == sent_count && exp_q.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            report_error($sformatf("received %0d results for %0d items sent",
                                   recv_count, sent_count));
        end
    end

endmodule

`default_nettype wire
